// File: sched_pkg.sv
// Shared definitions for the task scheduler
// Field positions describe both the input header and the command-queue header
package sched_pkg;

    // Default sizes, overridden from the top level
    localparam int NUM_ACCS = 4;
    localparam int SUBQUEUE_LEN = 16;
    localparam int NUM_ACC_TYPES = 4;

    // Header word fields
    localparam int HDR_VALID_BIT = 0;
    localparam int HDR_FROM_DEP_BIT = 0;
    localparam int HDR_NUM_ARGS_L = 8;
    localparam int HDR_CMD_TYPE_L = 16;

    // Argument-flag word fields
    localparam int ARG_IDX_L = 0;
    localparam int ARG_FLAG_L = 4;

    localparam logic [7:0] CMD_TYPE_EXEC = 8'd1;
    localparam logic [1:0] DEFAULT_ARG_FLAG = 2'b11;
    localparam logic [7:0] ACK_OK_CODE = 8'h01;
    localparam logic [7:0] ACK_REJECT_CODE = 8'h00;
    localparam logic [31:0] EXT_TASK_TAG = 32'hB000_0000;
    localparam logic [31:0] GEN_TASK_TAG = 32'hF000_0000;

    typedef logic [33:0] task_type_t;
    typedef logic [63:0] task_id_t;
    typedef logic [63:0] word_t;

    typedef enum logic [3:0] {
        P_HEADER,
        P_TASK_ID,
        P_GEN_ID,
        P_PARENT_ID,
        P_TASK_TYPE,
        P_WAIT_SEL,
        P_WAIT_WR,
        P_ARGS,
        P_DRAIN,
        P_ACK
    } parse_state_e;

    typedef enum logic [3:0] {
        W_IDLE,
        W_CHECK,
        W_EVAL,
        W_TID,
        W_PID,
        W_FLAG,
        W_ARG,
        W_HDR,
        W_REJECT
    } wr_state_e;

    typedef enum logic [7:0] {
        ACK_OK = ACK_OK_CODE,
        ACK_REJECT = ACK_REJECT_CODE
    } ack_e;

endpackage

// File: sched_ifs.sv
`timescale 1ns/100ps
// Internal links of the scheduler
// One lookup and one placement are outstanding at most

// Type lookup, req starts a scan and done answers it once
interface sel_if #(
    parameter int NUM_ACCS = sched_pkg::NUM_ACCS
);
    import sched_pkg::*;

    logic req;
    task_type_t task_type;
    logic done;
    logic found;
    logic [$clog2(NUM_ACCS)-1:0] acc_id;

    modport parser (output req, task_type, input done, found, acc_id);
    modport selector (input req, task_type, output done, found, acc_id);
endinterface

// Placement of one task, arguments flow only after the space check passed
interface wr_if #(
    parameter int NUM_ACCS = sched_pkg::NUM_ACCS
);
    import sched_pkg::*;

    logic start;
    logic [$clog2(NUM_ACCS)-1:0] acc_id;
    task_id_t task_id;
    task_id_t ptask_id;
    logic [3:0] num_args;
    logic arg_valid;
    word_t arg_data;
    logic arg_ready;
    logic done;
    logic accepted;

    modport parser (
        output start, acc_id, task_id, ptask_id, num_args, arg_valid, arg_data,
        input  arg_ready, done, accepted
    );
    modport writer (
        input  start, acc_id, task_id, ptask_id, num_args, arg_valid, arg_data,
        output arg_ready, done, accepted
    );
endinterface

// File: stream_parser.sv
`timescale 1ns/100ps
// Message: header, task id (from-dep only), parent id, task type, then num_args words
// A rejected message is drained up to in_tlast before its ack
module stream_parser (
    input  logic clk,
    input  logic rstn,
    input  sched_pkg::word_t in_tdata,
    input  logic in_tvalid,
    output logic in_tready,
    input  logic in_tlast,
    output sched_pkg::word_t out_tdata,
    output logic out_tvalid,
    input  logic out_tready,
    sel_if.parser sel,
    wr_if.parser wr
);
    import sched_pkg::*;

    parse_state_e state;
    logic [31:0] id_cnt;
    logic msg_end;
    ack_e ack;

    always_comb begin
        case (state)
            // Hold off the next header until the previous ack is gone
            P_HEADER: in_tready = out_tready;
            P_TASK_ID, P_PARENT_ID, P_TASK_TYPE, P_DRAIN: in_tready = 1'b1;
            P_ARGS: in_tready = wr.arg_ready;
            default: in_tready = 1'b0;
        endcase
    end

    assign out_tvalid = state == P_ACK;
    assign out_tdata = {56'd0, ack};
    assign wr.arg_valid = state == P_ARGS && in_tvalid;
    assign wr.arg_data = in_tdata;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= P_HEADER;
            sel.req <= 1'b0;
            wr.start <= 1'b0;
            id_cnt <= '0;
        end else begin
            sel.req <= 1'b0;
            wr.start <= 1'b0;
            if (wr.done && wr.accepted) begin
                id_cnt <= id_cnt + 1;
            end
            case (state)
                P_HEADER: begin
                    if (in_tvalid && out_tready) begin
                        state <= in_tdata[HDR_FROM_DEP_BIT] ? P_TASK_ID : P_GEN_ID;
                    end
                end
                P_TASK_ID: if (in_tvalid) state <= P_PARENT_ID;
                P_GEN_ID: state <= P_PARENT_ID;
                P_PARENT_ID: if (in_tvalid) state <= P_TASK_TYPE;
                P_TASK_TYPE: begin
                    if (in_tvalid) begin
                        sel.req <= 1'b1;
                        state <= P_WAIT_SEL;
                    end
                end
                P_WAIT_SEL: begin
                    if (sel.done && sel.found) begin
                        wr.start <= 1'b1;
                        state <= P_WAIT_WR;
                    end else if (sel.done) begin
                        state <= msg_end ? P_ACK : P_DRAIN;
                    end
                end
                P_WAIT_WR, P_ARGS: begin
                    if (wr.done) begin
                        state <= (wr.accepted || msg_end) ? P_ACK : P_DRAIN;
                    end else if (wr.arg_ready) begin
                        state <= P_ARGS;
                    end
                end
                P_DRAIN: if (in_tvalid && in_tlast) state <= P_ACK;
                P_ACK: if (out_tready) state <= P_HEADER;
                default: state <= P_HEADER;
            endcase
        end
    end

    // Task fields, held for the writer until its done
    always_ff @(posedge clk) begin
        case (state)
            P_HEADER: wr.num_args <= in_tdata[HDR_NUM_ARGS_L +: 4];
            P_TASK_ID: wr.task_id <= {EXT_TASK_TAG, in_tdata[31:0]};
            P_GEN_ID: wr.task_id <= {GEN_TASK_TAG, id_cnt};
            P_PARENT_ID: wr.ptask_id <= in_tdata;
            P_TASK_TYPE: begin
                sel.task_type <= in_tdata[$bits(task_type_t)-1:0];
                msg_end <= in_tlast;
            end
            P_WAIT_SEL: begin
                wr.acc_id <= sel.acc_id;
                ack <= ACK_REJECT;
            end
            P_WAIT_WR, P_ARGS: if (wr.done) ack <= wr.accepted ? ACK_OK : ACK_REJECT;
            default: ;
        endcase
    end

endmodule

// File: acc_selector.sv
`timescale 1ns/100ps
// Type table scanned one entry per cycle, first match wins
// Writing an entry restarts its round-robin pointer at first_acc
module acc_selector #(
    parameter int NUM_ACCS = sched_pkg::NUM_ACCS,
    parameter int NUM_ACC_TYPES = sched_pkg::NUM_ACC_TYPES
) (
    input  logic clk,
    input  logic rstn,
    input  logic cfg_we,
    input  logic [$clog2(NUM_ACC_TYPES)-1:0] cfg_idx,
    input  sched_pkg::task_type_t cfg_type,
    input  logic [$clog2(NUM_ACCS)-1:0] cfg_first_acc,
    input  logic [$clog2(NUM_ACCS):0] cfg_count,
    sel_if.selector sel
);
    import sched_pkg::*;

    localparam int ACC_W = $clog2(NUM_ACCS);
    localparam int TYPE_W = $clog2(NUM_ACC_TYPES);

    task_type_t tbl_type [NUM_ACC_TYPES];
    logic [ACC_W-1:0] tbl_first [NUM_ACC_TYPES];
    logic [ACC_W:0] tbl_count [NUM_ACC_TYPES];
    logic [NUM_ACC_TYPES-1:0] tbl_valid;
    logic [ACC_W-1:0] rr_ptr [NUM_ACC_TYPES];
    logic [TYPE_W-1:0] idx;
    logic busy;
    logic hit;

    assign hit = tbl_valid[idx] && tbl_count[idx] != 0 && tbl_type[idx] == sel.task_type;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy <= 1'b0;
            idx <= '0;
            sel.done <= 1'b0;
            tbl_valid <= '0;
            for (int i = 0; i < NUM_ACC_TYPES; i++) begin
                rr_ptr[i] <= '0;
            end
        end else begin
            sel.done <= 1'b0;
            if (cfg_we) begin
                tbl_valid[cfg_idx] <= 1'b1;
                rr_ptr[cfg_idx] <= '0;
            end
            if (sel.req) begin
                busy <= 1'b1;
                idx <= '0;
            end else if (busy) begin
                if (hit || idx == TYPE_W'(NUM_ACC_TYPES - 1)) begin
                    busy <= 1'b0;
                    sel.done <= 1'b1;
                end else begin
                    idx <= idx + 1;
                end
                // Wrap after count-1
                if (hit) begin
                    rr_ptr[idx] <= ({1'b0, rr_ptr[idx]} + 1 == tbl_count[idx]) ? '0
                                   : rr_ptr[idx] + 1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_we) begin
            tbl_type[cfg_idx] <= cfg_type;
            tbl_first[cfg_idx] <= cfg_first_acc;
            tbl_count[cfg_idx] <= cfg_count;
        end
        if (busy) begin
            sel.found <= hit;
            sel.acc_id <= tbl_first[idx] + rr_ptr[idx];
        end
    end

endmodule

// File: subqueue_writer.sv
`timescale 1ns/100ps
// Entry layout from its base slot: header, task id, parent id, flag/argument pairs
// The header goes in last, so a consumer never sees a half-written entry
// Ring indices wrap on their own, SUBQUEUE_LEN must be a power of two
module subqueue_writer #(
    parameter int NUM_ACCS = sched_pkg::NUM_ACCS,
    parameter int SUBQUEUE_LEN = sched_pkg::SUBQUEUE_LEN
) (
    input  logic clk,
    input  logic rstn,
    output logic [$clog2(NUM_ACCS)+$clog2(SUBQUEUE_LEN)-1:0] cmdq_addr,
    output logic cmdq_en,
    output logic cmdq_we,
    output sched_pkg::word_t cmdq_din,
    input  sched_pkg::word_t cmdq_dout,
    output logic nempty_write,
    output logic [$clog2(NUM_ACCS)-1:0] nempty_acc,
    wr_if.writer wr
);
    import sched_pkg::*;

    localparam int SQ_W = $clog2(SUBQUEUE_LEN);
    localparam logic [SQ_W:0] RING_FREE = (SQ_W+1)'(SUBQUEUE_LEN);

    wr_state_e state;
    logic [SQ_W-1:0] rd_idx_q [NUM_ACCS];
    logic [SQ_W-1:0] wr_idx_q [NUM_ACCS];
    logic [SQ_W:0] free_q [NUM_ACCS];

    // Working copy of the selected ring
    logic [SQ_W-1:0] rd;
    logic [SQ_W-1:0] base;
    logic [SQ_W:0] free;
    logic [5:0] needed;
    logic [SQ_W-1:0] ofs;
    logic [3:0] arg_i;
    logic [SQ_W-1:0] slot;
    logic [5:0] hdr_slots;
    logic fits;

    // Slots held by the consumed entry just read back
    assign hdr_slots = 6'd3 + {1'b0, cmdq_dout[HDR_NUM_ARGS_L +: 4], 1'b0};
    assign fits = int'(needed) <= int'(free);
    assign cmdq_addr = {wr.acc_id, slot};
    assign nempty_acc = wr.acc_id;

    always_comb begin
        slot = base + ofs;
        cmdq_en = 1'b0;
        cmdq_we = 1'b0;
        cmdq_din = wr.task_id;
        wr.arg_ready = 1'b0;
        wr.done = 1'b0;
        wr.accepted = 1'b0;
        nempty_write = 1'b0;
        case (state)
            W_CHECK: begin
                slot = rd;
                cmdq_en = !fits && free != RING_FREE;
            end
            W_TID: begin
                cmdq_en = 1'b1;
                cmdq_we = 1'b1;
            end
            W_PID: begin
                cmdq_en = 1'b1;
                cmdq_we = 1'b1;
                cmdq_din = wr.ptask_id;
            end
            W_FLAG: begin
                cmdq_en = 1'b1;
                cmdq_we = 1'b1;
                cmdq_din = '0;
                cmdq_din[ARG_IDX_L +: 4] = arg_i;
                cmdq_din[ARG_FLAG_L +: 2] = DEFAULT_ARG_FLAG;
            end
            W_ARG: begin
                wr.arg_ready = 1'b1;
                cmdq_en = wr.arg_valid;
                cmdq_we = wr.arg_valid;
                cmdq_din = wr.arg_data;
            end
            W_HDR: begin
                slot = base;
                cmdq_en = 1'b1;
                cmdq_we = 1'b1;
                cmdq_din = '0;
                cmdq_din[HDR_VALID_BIT] = 1'b1;
                cmdq_din[HDR_NUM_ARGS_L +: 4] = wr.num_args;
                cmdq_din[HDR_CMD_TYPE_L +: 8] = CMD_TYPE_EXEC;
                nempty_write = 1'b1;
                wr.done = 1'b1;
                wr.accepted = 1'b1;
            end
            W_REJECT: wr.done = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= W_IDLE;
            for (int i = 0; i < NUM_ACCS; i++) begin
                rd_idx_q[i] <= '0;
                wr_idx_q[i] <= '0;
                free_q[i] <= RING_FREE;
            end
        end else begin
            case (state)
                W_IDLE: if (wr.start) state <= W_CHECK;
                W_CHECK: begin
                    if (fits) begin
                        state <= W_TID;
                    end else if (free == RING_FREE) begin
                        // Task larger than the whole ring
                        state <= W_REJECT;
                    end else begin
                        state <= W_EVAL;
                    end
                end
                W_EVAL: state <= cmdq_dout[HDR_VALID_BIT] ? W_REJECT : W_CHECK;
                W_TID: state <= W_PID;
                W_PID: state <= (wr.num_args == 0) ? W_HDR : W_FLAG;
                W_FLAG: state <= W_ARG;
                W_ARG: begin
                    if (wr.arg_valid) begin
                        state <= (arg_i == wr.num_args - 1) ? W_HDR : W_FLAG;
                    end
                end
                W_HDR: begin
                    wr_idx_q[wr.acc_id] <= base + SQ_W'(needed);
                    rd_idx_q[wr.acc_id] <= rd;
                    free_q[wr.acc_id] <= free - (SQ_W+1)'(needed);
                    state <= W_IDLE;
                end
                W_REJECT: begin
                    // Keep whatever was reclaimed
                    rd_idx_q[wr.acc_id] <= rd;
                    free_q[wr.acc_id] <= free;
                    state <= W_IDLE;
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            W_IDLE: begin
                rd <= rd_idx_q[wr.acc_id];
                base <= wr_idx_q[wr.acc_id];
                free <= free_q[wr.acc_id];
                needed <= 6'd3 + {1'b0, wr.num_args, 1'b0};
                ofs <= SQ_W'(1);
                arg_i <= '0;
            end
            W_EVAL: begin
                if (!cmdq_dout[HDR_VALID_BIT]) begin
                    rd <= rd + SQ_W'(hdr_slots);
                    free <= free + (SQ_W+1)'(hdr_slots);
                end
            end
            W_TID, W_PID, W_FLAG: ofs <= ofs + 1;
            W_ARG: begin
                if (wr.arg_valid) begin
                    ofs <= ofs + 1;
                    arg_i <= arg_i + 1;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: task_scheduler.sv
`timescale 1ns/100ps
// Task scheduler top, stream front end plus type table plus command-queue writer
// Command memory reads return data one cycle after cmdq_en
// NUM_ACCS, SUBQUEUE_LEN and NUM_ACC_TYPES must be powers of two, at least 2
module task_scheduler #(
    parameter int NUM_ACCS = sched_pkg::NUM_ACCS,
    parameter int SUBQUEUE_LEN = sched_pkg::SUBQUEUE_LEN,
    parameter int NUM_ACC_TYPES = sched_pkg::NUM_ACC_TYPES
) (
    input  logic clk,
    input  logic rstn,
    input  sched_pkg::word_t in_tdata,
    input  logic in_tvalid,
    output logic in_tready,
    input  logic in_tlast,
    output sched_pkg::word_t out_tdata,
    output logic out_tvalid,
    input  logic out_tready,
    output logic [$clog2(NUM_ACCS)+$clog2(SUBQUEUE_LEN)-1:0] cmdq_addr,
    output logic cmdq_en,
    output logic cmdq_we,
    output sched_pkg::word_t cmdq_din,
    input  sched_pkg::word_t cmdq_dout,
    output logic nempty_write,
    output logic [$clog2(NUM_ACCS)-1:0] nempty_acc,
    input  logic cfg_we,
    input  logic [$clog2(NUM_ACC_TYPES)-1:0] cfg_idx,
    input  sched_pkg::task_type_t cfg_type,
    input  logic [$clog2(NUM_ACCS)-1:0] cfg_first_acc,
    input  logic [$clog2(NUM_ACCS):0] cfg_count
);

    sel_if #(.NUM_ACCS(NUM_ACCS)) sel ();
    wr_if #(.NUM_ACCS(NUM_ACCS)) wr ();

    stream_parser stream_parser_inst (
        .clk(clk),
        .rstn(rstn),
        .in_tdata(in_tdata),
        .in_tvalid(in_tvalid),
        .in_tready(in_tready),
        .in_tlast(in_tlast),
        .out_tdata(out_tdata),
        .out_tvalid(out_tvalid),
        .out_tready(out_tready),
        .sel(sel.parser),
        .wr(wr.parser)
    );

    acc_selector #(
        .NUM_ACCS(NUM_ACCS),
        .NUM_ACC_TYPES(NUM_ACC_TYPES)
    ) acc_selector_inst (
        .clk(clk),
        .rstn(rstn),
        .cfg_we(cfg_we),
        .cfg_idx(cfg_idx),
        .cfg_type(cfg_type),
        .cfg_first_acc(cfg_first_acc),
        .cfg_count(cfg_count),
        .sel(sel.selector)
    );

    subqueue_writer #(
        .NUM_ACCS(NUM_ACCS),
        .SUBQUEUE_LEN(SUBQUEUE_LEN)
    ) subqueue_writer_inst (
        .clk(clk),
        .rstn(rstn),
        .cmdq_addr(cmdq_addr),
        .cmdq_en(cmdq_en),
        .cmdq_we(cmdq_we),
        .cmdq_din(cmdq_din),
        .cmdq_dout(cmdq_dout),
        .nempty_write(nempty_write),
        .nempty_acc(nempty_acc),
        .wr(wr.writer)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps
// Free-running 4 ns clock, rstn held low for the first 16 rising edges
module tb_clock_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
    end

endmodule

// File: task_scheduler_chk.sv
`timescale 1ns/100ps
// Port protocol checks, bound into every task_scheduler instance
// Nothing is checked while rstn is low
module task_scheduler_chk (
    input logic clk,
    input logic rstn,
    input logic cmdq_en,
    input logic cmdq_we,
    input logic in_tready,
    input logic out_tvalid,
    input logic out_tready,
    input sched_pkg::word_t out_tdata
);

    we_with_en: assert property (@(posedge clk) disable iff (!rstn) cmdq_we |-> cmdq_en)
        else $error("cmdq_we high without cmdq_en");

    // Ack must hold until it is taken
    ack_held: assert property (@(posedge clk) disable iff (!rstn)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata))
        else $error("ack changed or dropped before out_tready");

    no_overlap: assert property (@(posedge clk) disable iff (!rstn) !(in_tready && out_tvalid))
        else $error("in_tready and out_tvalid high together");

endmodule

bind task_scheduler task_scheduler_chk task_scheduler_chk_inst (
    .clk(clk),
    .rstn(rstn),
    .cmdq_en(cmdq_en),
    .cmdq_we(cmdq_we),
    .in_tready(in_tready),
    .out_tvalid(out_tvalid),
    .out_tready(out_tready),
    .out_tdata(out_tdata)
);

// File: tb_task_scheduler.sv
`timescale 1ns/100ps
// Runs the records of task_scheduler_tests.txt against task_scheduler with default sizes
// The command queue is modelled here, expected entry slots follow each ring's write index
// Records run strictly one after the other, a task is fully sent before its ack is awaited
module tb_task_scheduler;
    import sched_pkg::*;

    localparam int ACC_W = $clog2(NUM_ACCS);
    localparam int SQ_W = $clog2(SUBQUEUE_LEN);
    localparam int TYPE_W = $clog2(NUM_ACC_TYPES);
    localparam string TEST_FILE = "task_scheduler_tests.txt";

    logic clk;
    logic rstn;
    word_t in_tdata;
    logic in_tvalid;
    logic in_tready;
    logic in_tlast;
    word_t out_tdata;
    logic out_tvalid;
    logic out_tready;
    logic [ACC_W+SQ_W-1:0] cmdq_addr;
    logic cmdq_en;
    logic cmdq_we;
    word_t cmdq_din;
    word_t cmdq_dout = '0;
    logic nempty_write;
    logic [ACC_W-1:0] nempty_acc;
    logic cfg_we;
    logic [TYPE_W-1:0] cfg_idx;
    task_type_t cfg_type;
    logic [ACC_W-1:0] cfg_first_acc;
    logic [ACC_W:0] cfg_count;

    word_t cmdq_mem [NUM_ACCS*SUBQUEUE_LEN];
    logic drain_req;
    logic [ACC_W-1:0] drain_acc;
    logic [SQ_W-1:0] next_slot [NUM_ACCS];
    logic [ACC_W-1:0] pulse_acc;
    int pulse_total;
    int write_total;
    int cycles;
    int cycle_limit;
    int errors;
    int passed;
    int failed;
    int accepted_cnt;

    tb_clock_gen clock_gen_inst (
        .clk(clk),
        .rstn(rstn)
    );

    task_scheduler task_scheduler_inst (
        .clk(clk),
        .rstn(rstn),
        .in_tdata(in_tdata),
        .in_tvalid(in_tvalid),
        .in_tready(in_tready),
        .in_tlast(in_tlast),
        .out_tdata(out_tdata),
        .out_tvalid(out_tvalid),
        .out_tready(out_tready),
        .cmdq_addr(cmdq_addr),
        .cmdq_en(cmdq_en),
        .cmdq_we(cmdq_we),
        .cmdq_din(cmdq_din),
        .cmdq_dout(cmdq_dout),
        .nempty_write(nempty_write),
        .nempty_acc(nempty_acc),
        .cfg_we(cfg_we),
        .cfg_idx(cfg_idx),
        .cfg_type(cfg_type),
        .cfg_first_acc(cfg_first_acc),
        .cfg_count(cfg_count)
    );

    // Command queue, one-cycle read; a drain clears the valid bit of every slot of one ring
    always @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_ACCS * SUBQUEUE_LEN; i++) begin
                cmdq_mem[i] <= '0;
            end
        end else begin
            if (cmdq_en && cmdq_we) begin
                cmdq_mem[cmdq_addr] <= cmdq_din;
            end else if (cmdq_en) begin
                cmdq_dout <= cmdq_mem[cmdq_addr];
            end
            if (drain_req) begin
                for (int s = 0; s < SUBQUEUE_LEN; s++) begin
                    cmdq_mem[{drain_acc, SQ_W'(s)}][HDR_VALID_BIT] <= 1'b0;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rstn && nempty_write) begin
            pulse_total <= pulse_total + 1;
            pulse_acc <= nempty_acc;
        end
        if (rstn && cmdq_en && cmdq_we) begin
            write_total <= write_total + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Back-pressure on the ack stream
    initial begin : ready_gen
        int hold;
        hold = 0;
        out_tready = 1'b1;
        void'($urandom(32'h86f5e6bb));
        @(posedge rstn);
        forever begin
            @(posedge clk);
            #1;
            if (hold > 0) begin
                hold--;
                out_tready = 1'b0;
            end else if ($urandom % 8 == 0) begin
                hold = int'($urandom % 3);
                out_tready = 1'b0;
            end else begin
                out_tready = 1'b1;
            end
        end
    end

    task automatic check_ack(input ack_e got, input ack_e want);
        if (got !== want) begin
            $display("[FAIL] %0t: ack %0h, expected %0h", $time, got, want);
            errors++;
        end
    endtask

    task automatic check_word(input word_t got, input word_t want, input string what);
        if (got !== want) begin
            $display("[FAIL] %0t: %s %h, expected %h", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic check_acc(input logic [ACC_W-1:0] got, input logic [ACC_W-1:0] want);
        if (got !== want) begin
            $display("[FAIL] %0t: nempty_acc %0d, expected %0d", $time, got, want);
            errors++;
        end
    endtask

    task automatic check_count(input int got, input int want, input string what);
        if (got != want) begin
            $display("[FAIL] %0t: %0d %s, expected %0d", $time, got, what, want);
            errors++;
        end
    endtask

    task automatic check_entry(input logic [ACC_W-1:0] acc, input task_id_t tid,
                               input task_id_t pid, input int nargs, input word_t args [16]);
        logic [SQ_W-1:0] base;
        word_t want;
        base = next_slot[acc];
        want = '0;
        want[HDR_VALID_BIT] = 1'b1;
        want[HDR_NUM_ARGS_L +: 4] = 4'(nargs);
        want[HDR_CMD_TYPE_L +: 8] = CMD_TYPE_EXEC;
        check_word(cmdq_mem[{acc, base}], want, "header");
        check_word(cmdq_mem[{acc, base + SQ_W'(1)}], tid, "task id");
        check_word(cmdq_mem[{acc, base + SQ_W'(2)}], pid, "parent id");
        for (int i = 0; i < nargs; i++) begin
            want = '0;
            want[ARG_IDX_L +: 4] = 4'(i);
            want[ARG_FLAG_L +: 2] = DEFAULT_ARG_FLAG;
            check_word(cmdq_mem[{acc, base + SQ_W'(3 + 2 * i)}], want, "argument flag");
            check_word(cmdq_mem[{acc, base + SQ_W'(4 + 2 * i)}], args[i], "argument");
        end
    endtask

    // Called and returns 1 ns after a rising edge
    task automatic send_word(input word_t data, input logic last);
        logic taken;
        in_tdata = data;
        in_tlast = last;
        in_tvalid = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_tready;
            @(posedge clk);
            #1;
        end
        in_tvalid = 1'b0;
        in_tlast = 1'b0;
    endtask

    task automatic wait_ack(output ack_e ack);
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            seen = out_tvalid && out_tready;
            ack = ack_e'(out_tdata[7:0]);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic write_config(input word_t idx, input word_t ttype, input word_t first,
                                input word_t count);
        cfg_idx = idx[TYPE_W-1:0];
        cfg_type = ttype[$bits(task_type_t)-1:0];
        cfg_first_acc = first[ACC_W-1:0];
        cfg_count = count[ACC_W:0];
        cfg_we = 1'b1;
        @(posedge clk);
        #1;
        cfg_we = 1'b0;
    endtask

    task automatic drain_ring(input word_t acc);
        drain_acc = acc[ACC_W-1:0];
        drain_req = 1'b1;
        @(posedge clk);
        #1;
        drain_req = 1'b0;
    endtask

    task automatic run_task(input int fd);
        word_t from_dep;
        word_t id;
        word_t parent;
        word_t ttype;
        word_t nargs_w;
        word_t ack_w;
        word_t acc_w;
        word_t args [16];
        word_t hdr;
        task_id_t tid;
        int nargs;
        int code;
        int err0;
        int pulses0;
        int writes0;
        ack_e got;
        logic [ACC_W-1:0] acc;
        code = $fscanf(fd, "%h %h %h %h %h %h %h", from_dep, id, parent, ttype, nargs_w,
                       ack_w, acc_w);
        if (code != 7) begin
            $display("Task record %0d is malformed", passed + failed + 1);
            errors++;
        end
        nargs = int'(nargs_w[3:0]);
        acc = acc_w[ACC_W-1:0];
        for (int i = 0; i < nargs; i++) begin
            code = $fscanf(fd, "%h", args[i]);
        end
        err0 = errors;
        pulses0 = pulse_total;
        writes0 = write_total;
        // Id the scheduler should store, generated ids count accepted tasks
        if (from_dep[0]) begin
            tid = {EXT_TASK_TAG, id[31:0]};
        end else begin
            tid = {GEN_TASK_TAG, 32'(accepted_cnt)};
        end
        hdr = '0;
        hdr[HDR_FROM_DEP_BIT] = from_dep[0];
        hdr[HDR_NUM_ARGS_L +: 4] = 4'(nargs);
        send_word(hdr, 1'b0);
        if (from_dep[0]) begin
            send_word(id, 1'b0);
        end
        send_word(parent, 1'b0);
        send_word(ttype, nargs == 0);
        for (int i = 0; i < nargs; i++) begin
            send_word(args[i], i == nargs - 1);
        end
        wait_ack(got);
        check_ack(got, ack_e'(ack_w[7:0]));
        if (ack_e'(ack_w[7:0]) == ACK_OK) begin
            check_count(pulse_total - pulses0, 1, "nempty pulses");
            check_acc(pulse_acc, acc);
            check_count(write_total - writes0, 3 + 2 * nargs, "memory writes");
            check_entry(acc, tid, parent, nargs, args);
            next_slot[acc] = next_slot[acc] + SQ_W'(3 + 2 * nargs);
            accepted_cnt++;
        end else begin
            check_count(pulse_total - pulses0, 0, "nempty pulses");
            check_count(write_total - writes0, 0, "memory writes");
        end
        if (errors == err0) begin
            passed++;
        end else begin
            failed++;
        end
        $display("test %0d: acc %0d ack %0h %s", passed + failed, acc, ack_w[7:0],
                 errors == err0 ? "passed" : "failed");
    endtask

    task automatic run_records(input int fd);
        byte kind;
        int code;
        word_t f0;
        word_t f1;
        word_t f2;
        word_t f3;
        logic [8*256-1:0] rest;
        while ($fscanf(fd, " %c", kind) == 1) begin
            case (kind)
                "#": code = $fgets(rest, fd);
                "C": begin
                    code = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                    write_config(f0, f1, f2, f3);
                end
                "D": begin
                    code = $fscanf(fd, "%h", f0);
                    drain_ring(f0);
                end
                "T": run_task(fd);
                default: begin
                    $display("Unknown record kind %c in the test file", kind);
                    errors++;
                    code = $fgets(rest, fd);
                end
            endcase
        end
    endtask

    function automatic int count_records();
        int fd;
        int n;
        int code;
        byte kind;
        logic [8*256-1:0] rest;
        n = 0;
        fd = $fopen(TEST_FILE, "r");
        if (fd != 0) begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                if (kind != "#") begin
                    n++;
                end
                code = $fgets(rest, fd);
            end
            $fclose(fd);
        end
        return n;
    endfunction

    initial begin
        int fd;
        $timeformat(-9, 1, " ns", 0);
        in_tdata = '0;
        in_tvalid = 1'b0;
        in_tlast = 1'b0;
        cfg_we = 1'b0;
        cfg_idx = '0;
        cfg_type = '0;
        cfg_first_acc = '0;
        cfg_count = '0;
        drain_req = 1'b0;
        drain_acc = '0;
        for (int i = 0; i < NUM_ACCS; i++) begin
            next_slot[i] = '0;
        end
        cycle_limit = 200 * count_records() + 16;
        fd = $fopen(TEST_FILE, "r");
        @(posedge rstn);
        @(posedge clk);
        #1;
        if (out_tvalid || cmdq_en || cmdq_we || nempty_write) begin
            $display("Outputs were active right after reset at %0t", $time);
            errors++;
        end
        if (fd == 0) begin
            $display("Could not open %s", TEST_FILE);
            errors++;
        end else begin
            run_records(fd);
            $fclose(fd);
        end
        if (passed + failed == 0) begin
            $display("No task record was run");
            errors++;
        end
        $display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: task_scheduler_tests.txt
# C idx type first_acc count | D acc | T from_dep id parent type nargs ack acc args...
# All values hex, ack 01 is OK and 00 reject, acc is ignored for a rejected task
C 0 00000000a 1 3
C 1 00000000b 0 1
T 0 0 1000 a 1 01 1 aaaa0001
T 0 0 1001 a 1 01 2 aaaa0002
T 0 0 1002 a 1 01 3 aaaa0003
T 0 0 1003 a 1 01 1 aaaa0004
T 1 12345678 2000 a 2 01 2 bbbb0001 bbbb0002
T 0 0 3000 b 2 01 0 cccc0001 cccc0002
T 0 0 3001 b 2 01 0 cccc0003 cccc0004
T 0 0 3002 b 3 00 0 dddd0001 dddd0002 dddd0003
T 0 0 4000 c 2 00 0 eeee0001 eeee0002
D 0
T 0 0 3002 b 3 01 0 dddd0001 dddd0002 dddd0003
T 1 9abcdef0 5000 b 0 01 0
T 0 0 6000 a 0 01 3

// File: task_scheduler.f
sched_pkg.sv
sched_ifs.sv
stream_parser.sv
acc_selector.sv
subqueue_writer.sv
task_scheduler.sv
tb_clock_gen.sv
task_scheduler_chk.sv
tb_task_scheduler.sv

// File: Makefile
# Verilator build and run of tb_task_scheduler, output goes to sim.log

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, fails if sim.log reports failure"
	@echo "make clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_task_scheduler \
		-f task_scheduler.f -Mdir obj_dir
	./obj_dir/Vtb_task_scheduler > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
